// File: mem_pkg.sv
// Shared widths and types for the instruction and data cache subsystem
// Imported by the caches, the bus arbiter and the testbench

package mem_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int ADDR_WIDTH  = 32;  // Byte address
  localparam int DATA_WIDTH  = 64;  // One word, also one cache line
  localparam int OFFSET_BITS = 3;   // Byte offset inside a word

  ////////////////////
  // Types
  ////////////////////

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] word_t;

  // Command on the external memory bus
  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_cmd_e;

endpackage

// File: mem_bus_if.sv
// Request and response path between one cache controller and the bus arbiter
// One instance per cache; the cache takes the client side

`timescale 1ns/10ps

interface mem_bus_if import mem_pkg::*; ();

  logic     req_valid;   // From the cache
  bus_cmd_e cmd;
  addr_t    addr;
  word_t    wdata;

  logic     req_ready;   // From the arbiter
  logic     resp_valid;
  word_t    rdata;

  modport client (
    output req_valid, cmd, addr, wdata,
    input  req_ready, resp_valid, rdata
  );

  modport arbiter (
    input  req_valid, cmd, addr, wdata,
    output req_ready, resp_valid, rdata
  );

endinterface

// File: cache_lines.sv
// Direct-mapped cache storage with one 64-bit word per line
// Combinational read with hit detect, one line write per cycle

`timescale 1ns/10ps

module cache_lines import mem_pkg::*; #(
  parameter int LINE_COUNT = 32
) (
  input  logic  clock,
  input  logic  rst,
  input  addr_t rd_addr,
  output logic  hit,
  output word_t rd_data,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  word_t wr_data
);

  localparam int INDEX_BITS = $clog2(LINE_COUNT);
  localparam int TAG_BITS   = ADDR_WIDTH - OFFSET_BITS - INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  tag_t                  tags  [LINE_COUNT];
  word_t                 lines [LINE_COUNT];
  logic [LINE_COUNT-1:0] valid;

  index_t rd_index;
  index_t wr_index;
  tag_t   rd_tag;
  tag_t   wr_tag;

  // Address split, byte offset dropped
  assign rd_index = rd_addr[OFFSET_BITS +: INDEX_BITS];
  assign rd_tag   = rd_addr[ADDR_WIDTH-1 -: TAG_BITS];
  assign wr_index = wr_addr[OFFSET_BITS +: INDEX_BITS];
  assign wr_tag   = wr_addr[ADDR_WIDTH-1 -: TAG_BITS];

  assign hit     = valid[rd_index] && (tags[rd_index] == rd_tag);
  assign rd_data = lines[rd_index];

  always_ff @(posedge clock)
  begin
    if (rst)
      valid <= '0;           // Caches start empty
    else if (wr_en)
      valid[wr_index] <= 1'b1;
  end

  // Tag and data arrays
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      tags[wr_index]  <= wr_tag;
      lines[wr_index] <= wr_data;
    end
  end

endmodule

// File: icache_ctrl.sv
// Read-only instruction cache controller
// Hits answer one cycle after the fetch, misses load the line over the bus

`timescale 1ns/10ps

module icache_ctrl import mem_pkg::*; #(
  parameter int LINE_COUNT = 32
) (
  input  logic      clock,
  input  logic      rst,
  input  logic      fetch_valid,
  output logic      fetch_ready,
  input  addr_t     fetch_addr,
  output logic      fetch_resp_valid,
  output word_t     fetch_data,
  output addr_t     lines_rd_addr,
  input  logic      lines_hit,
  input  word_t     lines_rd_data,
  output logic      lines_wr_en,
  output addr_t     lines_wr_addr,
  output word_t     lines_wr_data,
  mem_bus_if.client bus
);

  localparam int INDEX_BITS = $clog2(LINE_COUNT);
  localparam int TAG_BITS   = ADDR_WIDTH - OFFSET_BITS - INDEX_BITS;

  typedef enum logic [1:0] {IDLE, REQUEST, WAIT_FILL} state_e;

  state_e                state;
  logic [INDEX_BITS-1:0] miss_index;
  logic [TAG_BITS-1:0]   miss_tag;
  addr_t                 miss_addr;
  logic                  accept;

  assign fetch_ready = (state == IDLE);
  assign accept      = fetch_valid && fetch_ready;
  assign miss_addr   = {miss_tag, miss_index, {OFFSET_BITS{1'b0}}};  // Word aligned

  assign lines_rd_addr = fetch_addr;
  assign lines_wr_en   = (state == WAIT_FILL) && bus.resp_valid;  // Fill on return
  assign lines_wr_addr = miss_addr;
  assign lines_wr_data = bus.rdata;

  assign bus.req_valid = (state == REQUEST);
  assign bus.cmd       = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
  assign bus.addr      = miss_addr;
  assign bus.wdata     = '0;

  ////////////////////
  // Miss FSM
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      state            <= IDLE;
      fetch_resp_valid <= 1'b0;
    end
    else
    begin
      fetch_resp_valid <= 1'b0;
      case (state)
        IDLE:
          if (accept)
          begin
            if (lines_hit)
              fetch_resp_valid <= 1'b1;
            else
              state <= REQUEST;
          end
        REQUEST:
          if (bus.req_ready)
            state <= WAIT_FILL;
        WAIT_FILL:
          if (bus.resp_valid)
          begin
            fetch_resp_valid <= 1'b1;
            state            <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Miss address and response word
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      miss_tag   <= fetch_addr[ADDR_WIDTH-1 -: TAG_BITS];
      miss_index <= fetch_addr[OFFSET_BITS +: INDEX_BITS];
    end
    if (accept && lines_hit)
      fetch_data <= lines_rd_data;
    else if (lines_wr_en)
      fetch_data <= bus.rdata;   // Returned word goes straight out
  end

endmodule

// File: dcache_ctrl.sv
// Write-through data cache controller for loads and stores
// Load misses allocate, stores update on hit only and always go to memory

`timescale 1ns/10ps

module dcache_ctrl import mem_pkg::*; #(
  parameter int LINE_COUNT = 32
) (
  input  logic      clock,
  input  logic      rst,
  input  logic      data_valid,
  output logic      data_ready,
  input  logic      data_write,
  input  addr_t     data_addr,
  input  word_t     data_wdata,
  output logic      data_resp_valid,
  output word_t     data_rdata,
  output addr_t     lines_rd_addr,
  input  logic      lines_hit,
  input  word_t     lines_rd_data,
  output logic      lines_wr_en,
  output addr_t     lines_wr_addr,
  output word_t     lines_wr_data,
  mem_bus_if.client bus
);

  localparam int INDEX_BITS = $clog2(LINE_COUNT);
  localparam int TAG_BITS   = ADDR_WIDTH - OFFSET_BITS - INDEX_BITS;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_REQ,
    LOAD_WAIT,
    STORE_REQ,
    STORE_WAIT
  } state_e;

  state_e                state;
  logic [INDEX_BITS-1:0] req_index;
  logic [TAG_BITS-1:0]   req_tag;
  addr_t                 req_addr;
  word_t                 req_wdata;
  logic                  accept;
  logic                  load_hit;
  logic                  store_hit;
  logic                  fill;

  assign data_ready = (state == IDLE);
  assign accept     = data_valid && data_ready;
  assign load_hit   = accept && !data_write && lines_hit;
  assign store_hit  = accept && data_write && lines_hit;
  assign fill       = (state == LOAD_WAIT) && bus.resp_valid;
  assign req_addr   = {req_tag, req_index, {OFFSET_BITS{1'b0}}};

  // Store hit writes at acceptance, load fill writes on return
  assign lines_rd_addr = data_addr;
  assign lines_wr_en   = store_hit || fill;
  assign lines_wr_addr = store_hit ? data_addr : req_addr;
  assign lines_wr_data = store_hit ? data_wdata : bus.rdata;

  assign bus.req_valid = (state == LOAD_REQ) || (state == STORE_REQ);
  assign bus.addr      = req_addr;
  assign bus.wdata     = req_wdata;

  always_comb
  begin
    case (state)
      LOAD_REQ:  bus.cmd = BUS_LOAD;
      STORE_REQ: bus.cmd = BUS_STORE;
      default:   bus.cmd = BUS_NONE;
    endcase
  end

  ////////////////////
  // Access FSM
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      state           <= IDLE;
      data_resp_valid <= 1'b0;
    end
    else
    begin
      data_resp_valid <= 1'b0;
      case (state)
        IDLE:
          if (accept)
          begin
            if (data_write)
              state <= STORE_REQ;        // Write-through, every store
            else if (lines_hit)
              data_resp_valid <= 1'b1;
            else
              state <= LOAD_REQ;
          end
        LOAD_REQ:
          if (bus.req_ready)
            state <= LOAD_WAIT;
        LOAD_WAIT:
          if (bus.resp_valid)
          begin
            data_resp_valid <= 1'b1;
            state           <= IDLE;
          end
        STORE_REQ:
          if (bus.req_ready)
            state <= STORE_WAIT;
        STORE_WAIT:
          if (bus.resp_valid)
            state <= IDLE;               // No response to the client
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      req_tag   <= data_addr[ADDR_WIDTH-1 -: TAG_BITS];
      req_index <= data_addr[OFFSET_BITS +: INDEX_BITS];
      req_wdata <= data_wdata;
    end
    if (load_hit)
      data_rdata <= lines_rd_data;
    else if (fill)
      data_rdata <= bus.rdata;
  end

endmodule

// File: bus_arbiter.sv
// Shares the external memory bus between the instruction and data caches
// Data side wins when both ask; the owner holds the bus until its response

`timescale 1ns/10ps

module bus_arbiter import mem_pkg::*; (
  input  logic       clock,
  input  logic       rst,
  mem_bus_if.arbiter i_bus,
  mem_bus_if.arbiter d_bus,
  output logic       mem_req_valid,
  input  logic       mem_req_ready,
  output bus_cmd_e   mem_command,
  output addr_t      mem_addr,
  output word_t      mem_wdata,
  input  logic       mem_resp_valid,
  input  word_t      mem_rdata
);

  typedef enum logic [1:0] {OWN_NONE, OWN_I, OWN_D} owner_e;

  owner_e owner;
  logic   sel_d;
  logic   sel_i;

  // Grant is combinational when free, no added cycle
  assign sel_d = (owner == OWN_D) || ((owner == OWN_NONE) && d_bus.req_valid);
  assign sel_i = (owner == OWN_I) ||
                 ((owner == OWN_NONE) && !d_bus.req_valid && i_bus.req_valid);

  always_comb
  begin
    mem_req_valid = 1'b0;
    mem_command   = BUS_NONE;
    mem_addr      = '0;
    mem_wdata     = '0;
    if (sel_d)
    begin
      mem_req_valid = d_bus.req_valid;
      mem_command   = d_bus.cmd;
      mem_addr      = d_bus.addr;
      mem_wdata     = d_bus.wdata;
    end
    else if (sel_i)
    begin
      mem_req_valid = i_bus.req_valid;
      mem_command   = i_bus.cmd;
      mem_addr      = i_bus.addr;
      mem_wdata     = i_bus.wdata;
    end
  end

  assign d_bus.req_ready  = sel_d && mem_req_ready;
  assign i_bus.req_ready  = sel_i && mem_req_ready;
  assign d_bus.resp_valid = (owner == OWN_D) && mem_resp_valid;  // Owner only
  assign i_bus.resp_valid = (owner == OWN_I) && mem_resp_valid;
  assign d_bus.rdata      = mem_rdata;
  assign i_bus.rdata      = mem_rdata;

  // Owner held from grant through the memory response
  always_ff @(posedge clock)
  begin
    if (rst)
      owner <= OWN_NONE;
    else
    begin
      case (owner)
        OWN_NONE:
          if (d_bus.req_valid)
            owner <= OWN_D;
          else if (i_bus.req_valid)
            owner <= OWN_I;
        default:
          if (mem_resp_valid)
            owner <= OWN_NONE;
      endcase
    end
  end

endmodule

// File: mem_subsystem.sv
// Memory subsystem top: instruction cache, data cache and bus arbiter
// Client and memory sides are plain valid/ready ports

`timescale 1ns/10ps

module mem_subsystem import mem_pkg::*; #(
  parameter int LINE_COUNT = 32
) (
  input  logic     clock,
  input  logic     rst,
  // Fetch side
  input  logic     fetch_valid,
  output logic     fetch_ready,
  input  addr_t    fetch_addr,
  output logic     fetch_resp_valid,
  output word_t    fetch_data,
  // Load and store side
  input  logic     data_valid,
  output logic     data_ready,
  input  logic     data_write,
  input  addr_t    data_addr,
  input  word_t    data_wdata,
  output logic     data_resp_valid,
  output word_t    data_rdata,
  // External memory
  output logic     mem_req_valid,
  input  logic     mem_req_ready,
  output bus_cmd_e mem_command,
  output addr_t    mem_addr,
  output word_t    mem_wdata,
  input  logic     mem_resp_valid,
  input  word_t    mem_rdata
);

  addr_t ic_rd_addr;
  logic  ic_hit;
  word_t ic_rd_data;
  logic  ic_wr_en;
  addr_t ic_wr_addr;
  word_t ic_wr_data;

  addr_t dc_rd_addr;
  logic  dc_hit;
  word_t dc_rd_data;
  logic  dc_wr_en;
  addr_t dc_wr_addr;
  word_t dc_wr_data;

  mem_bus_if i_bus ();
  mem_bus_if d_bus ();

  ////////////////////
  // Instruction side
  ////////////////////

  cache_lines #(.LINE_COUNT(LINE_COUNT)) icache_lines (
    .clock(clock), .rst(rst),
    .rd_addr(ic_rd_addr), .hit(ic_hit), .rd_data(ic_rd_data),
    .wr_en(ic_wr_en), .wr_addr(ic_wr_addr), .wr_data(ic_wr_data)
  );

  icache_ctrl #(.LINE_COUNT(LINE_COUNT)) icache (
    .clock(clock), .rst(rst),
    .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_addr(fetch_addr),
    .fetch_resp_valid(fetch_resp_valid), .fetch_data(fetch_data),
    .lines_rd_addr(ic_rd_addr), .lines_hit(ic_hit), .lines_rd_data(ic_rd_data),
    .lines_wr_en(ic_wr_en), .lines_wr_addr(ic_wr_addr), .lines_wr_data(ic_wr_data),
    .bus(i_bus.client)
  );

  ////////////////////
  // Data side
  ////////////////////

  cache_lines #(.LINE_COUNT(LINE_COUNT)) dcache_lines (
    .clock(clock), .rst(rst),
    .rd_addr(dc_rd_addr), .hit(dc_hit), .rd_data(dc_rd_data),
    .wr_en(dc_wr_en), .wr_addr(dc_wr_addr), .wr_data(dc_wr_data)
  );

  dcache_ctrl #(.LINE_COUNT(LINE_COUNT)) dcache (
    .clock(clock), .rst(rst),
    .data_valid(data_valid), .data_ready(data_ready), .data_write(data_write),
    .data_addr(data_addr), .data_wdata(data_wdata),
    .data_resp_valid(data_resp_valid), .data_rdata(data_rdata),
    .lines_rd_addr(dc_rd_addr), .lines_hit(dc_hit), .lines_rd_data(dc_rd_data),
    .lines_wr_en(dc_wr_en), .lines_wr_addr(dc_wr_addr), .lines_wr_data(dc_wr_data),
    .bus(d_bus.client)
  );

  // Shared memory bus
  bus_arbiter arbiter (
    .clock(clock), .rst(rst),
    .i_bus(i_bus.arbiter), .d_bus(d_bus.arbiter),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
    .mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_resp_valid(mem_resp_valid), .mem_rdata(mem_rdata)
  );

endmodule

// File: mem_checker.sv
// Response checker for the memory subsystem, watches the DUT ports only
// Keeps a shadow of stored data and one expected-address queue per port
// Error counters are read by the testbench top for the closing report

`timescale 1ns/10ps

module mem_checker import mem_pkg::*; (
  input logic     clock,
  input logic     rst,
  input logic     fetch_valid,
  input logic     fetch_ready,
  input addr_t    fetch_addr,
  input logic     fetch_resp_valid,
  input word_t    fetch_data,
  input logic     data_valid,
  input logic     data_ready,
  input logic     data_write,
  input addr_t    data_addr,
  input word_t    data_wdata,
  input logic     data_resp_valid,
  input word_t    data_rdata,
  input logic     mem_req_valid,
  input logic     mem_req_ready,
  input bus_cmd_e mem_command,
  input addr_t    mem_addr,
  input word_t    mem_wdata
);

  localparam addr_t DATA_BASE = 32'h0000_1000;  // Fetches live below, data above

  word_t shadow [addr_t];   // Words written through the data port
  bit    fetched [addr_t];  // Fetch addresses seen since reset
  addr_t fetch_q [$];
  addr_t load_q [$];

  int    value_errors    = 0;
  int    protocol_errors = 0;
  int    open_fetches    = 0;
  int    open_loads      = 0;

  addr_t last_fetch;
  addr_t last_data;
  logic  last_fetch_ok = 1'b0;
  logic  last_was_load = 1'b0;
  logic  fetch_hit_due = 1'b0;  // Repeat fetch, answer expected this cycle
  logic  load_hit_due  = 1'b0;
  logic  first_open    = 1'b0;
  logic  first_loaded  = 1'b0;
  addr_t first_addr;

  // Memory contents before any store
  function automatic word_t init_word(input addr_t addr);
    return (word_t'(addr >> OFFSET_BITS) ^ 64'h5a5a_0000_c3c3_0000) + word_t'(addr);
  endfunction

  always @(posedge clock)
  begin : check
    addr_t expect_addr;
    word_t expect_word;
    if (rst)
    begin
      fetch_q.delete();
      load_q.delete();
      fetched.delete();
      last_fetch_ok = 1'b0;
      last_was_load = 1'b0;
      fetch_hit_due = 1'b0;
      load_hit_due  = 1'b0;
      first_open    = 1'b0;
    end
    else
    begin
      ////////////////////
      // Fetch port
      ////////////////////
      if (fetch_hit_due && !fetch_resp_valid)
      begin
        protocol_errors++;
        $display("Repeated fetch to 0x%h did not answer one cycle after acceptance", last_fetch);
      end
      if (fetch_hit_due && mem_req_valid && mem_addr < DATA_BASE)
      begin
        protocol_errors++;
        $display("Repeated fetch to 0x%h went out to the memory bus", last_fetch);
      end
      if (first_open && mem_req_valid && mem_req_ready && mem_command == BUS_LOAD &&
          mem_addr == first_addr)
        first_loaded = 1'b1;
      if (fetch_resp_valid)
      begin
        if (fetch_q.size() == 0)
        begin
          protocol_errors++;
          $display("Fetch response at %0t with no fetch outstanding", $time);
        end
        else
        begin
          expect_addr = fetch_q.pop_front();
          expect_word = init_word(expect_addr);
          if (fetch_data !== expect_word)
          begin
            value_errors++;
            $display("** Error at %0t: fetch 0x%h returned 0x%h, expected 0x%h",
                     $time, expect_addr, fetch_data, expect_word);
          end
          if (first_open && !first_loaded)
          begin
            protocol_errors++;
            $display("First fetch to 0x%h after reset was answered without a memory load",
                     expect_addr);
          end
          first_open = 1'b0;
        end
      end
      fetch_hit_due = 1'b0;
      if (fetch_valid && fetch_ready)
      begin
        fetch_hit_due = last_fetch_ok && (fetch_addr == last_fetch);
        if (!fetched.exists(fetch_addr))
        begin
          first_open   = 1'b1;   // Never fetched since reset, so this must miss
          first_loaded = 1'b0;
          first_addr   = fetch_addr;
          fetched[fetch_addr] = 1'b1;
        end
        last_fetch    = fetch_addr;
        last_fetch_ok = 1'b1;
        fetch_q.push_back(fetch_addr);
      end

      ////////////////////
      // Data port
      ////////////////////
      if (load_hit_due && !data_resp_valid)
      begin
        protocol_errors++;
        $display("Repeated load from 0x%h did not answer one cycle after acceptance", last_data);
      end
      if (load_hit_due && mem_req_valid && mem_addr >= DATA_BASE)
      begin
        protocol_errors++;
        $display("Repeated load from 0x%h went out to the memory bus", last_data);
      end
      // Write-through store carries the word accepted at the data port
      if (mem_req_valid && mem_req_ready && mem_command == BUS_STORE)
      begin
        if (last_was_load)
        begin
          protocol_errors++;
          $display("Bus store to 0x%h issued with no store accepted at the data port",
                   mem_addr);
        end
        else if (mem_addr !== last_data || mem_wdata !== shadow[last_data])
        begin
          value_errors++;
          $display("** Error at %0t: bus store 0x%h to 0x%h, expected 0x%h to 0x%h",
                   $time, mem_wdata, mem_addr, shadow[last_data], last_data);
        end
      end
      if (data_resp_valid)
      begin
        if (load_q.size() == 0)
        begin
          protocol_errors++;
          $display("Data response at %0t with no load outstanding", $time);
        end
        else
        begin
          expect_addr = load_q.pop_front();
          if (shadow.exists(expect_addr))
            expect_word = shadow[expect_addr];
          else
            expect_word = init_word(expect_addr);
          if (data_rdata !== expect_word)
          begin
            value_errors++;
            $display("** Error at %0t: load 0x%h returned 0x%h, expected 0x%h",
                     $time, expect_addr, data_rdata, expect_word);
          end
        end
      end
      load_hit_due = 1'b0;
      if (data_valid && data_ready)
      begin
        if (data_write)
        begin
          shadow[data_addr] = data_wdata;
          last_was_load     = 1'b0;   // Store may not allocate
        end
        else
        begin
          load_hit_due  = last_was_load && (data_addr == last_data);
          last_was_load = 1'b1;
          load_q.push_back(data_addr);
        end
        last_data = data_addr;
      end
      open_fetches = fetch_q.size();
      open_loads   = load_q.size();
    end
  end

endmodule

// File: tb_mem_subsystem.sv
// Testbench for the memory subsystem with a random-latency memory model
// Random fetch and data traffic first, then a quiet directed phase, then the report

`timescale 1ns/10ps

module tb_mem_subsystem import mem_pkg::*; ();

  localparam int    OP_COUNT       = 300;
  localparam int    TIMEOUT_CYCLES = 2 * OP_COUNT * 12 + 100;
  localparam addr_t DATA_BASE      = 32'h0000_1000;

  logic     clock;
  logic     rst;
  logic     fetch_valid;
  logic     fetch_ready;
  addr_t    fetch_addr;
  logic     fetch_resp_valid;
  word_t    fetch_data;
  logic     data_valid;
  logic     data_ready;
  logic     data_write;
  addr_t    data_addr;
  word_t    data_wdata;
  logic     data_resp_valid;
  word_t    data_rdata;
  logic     mem_req_valid;
  logic     mem_req_ready  = 1'b0;
  bus_cmd_e mem_command;
  addr_t    mem_addr;
  word_t    mem_wdata;
  logic     mem_resp_valid = 1'b0;
  word_t    mem_rdata      = '0;

  word_t memory [addr_t];   // Words written by bus stores
  logic  mem_busy = 1'b0;
  int    wait_count;
  word_t resp_word;
  int    cycles;
  int    missing;

  // Memory contents before any store
  function automatic word_t init_word(input addr_t addr);
    return (word_t'(addr >> OFFSET_BITS) ^ 64'h5a5a_0000_c3c3_0000) + word_t'(addr);
  endfunction

  mem_subsystem #(.LINE_COUNT(32)) DUT (.*);

  mem_checker mem_check (.*);

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////
  // Memory model
  ////////////////////

  always @(posedge clock)
  begin
    if (rst)
    begin
      mem_req_ready  <= 1'b0;
      mem_resp_valid <= 1'b0;
      mem_busy = 1'b0;
    end
    else
    begin
      mem_resp_valid <= 1'b0;
      if (mem_req_valid && mem_req_ready)
      begin
        if (mem_command == BUS_STORE)
        begin
          memory[mem_addr] = mem_wdata;
          resp_word = {$urandom, $urandom};   // Store data return is ignored
        end
        else if (memory.exists(mem_addr))
          resp_word = memory[mem_addr];
        else
          resp_word = init_word(mem_addr);
        mem_busy   = 1'b1;
        wait_count = $urandom % 4;            // Answer 1 to 4 cycles later
      end
      if (mem_busy)
      begin
        if (wait_count == 0)
        begin
          mem_resp_valid <= 1'b1;
          mem_rdata      <= resp_word;
          mem_busy = 1'b0;
        end
        else
          wait_count--;
      end
      mem_req_ready <= !mem_busy && (($urandom % 4) != 0);
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic run_fetches(input int count);
    int accepted;
    accepted = 0;
    while (accepted < count)
    begin
      @(posedge clock);
      if (fetch_valid && !fetch_ready)
        continue;                    // Held until accepted
      if (fetch_valid)
        accepted++;
      if (accepted < count && ($urandom % 4) != 0)
      begin
        fetch_valid <= 1'b1;
        fetch_addr  <= addr_t'(($urandom % 64) << OFFSET_BITS);
      end
      else
        fetch_valid <= 1'b0;
    end
  endtask

  task automatic run_data(input int count);
    int accepted;
    accepted = 0;
    while (accepted < count)
    begin
      @(posedge clock);
      if (data_valid && !data_ready)
        continue;
      if (data_valid)
        accepted++;
      if (accepted < count && ($urandom % 4) != 0)
      begin
        data_valid <= 1'b1;
        data_write <= ($urandom % 3) == 0;
        // 8 indexes, 3 tags each, so lines conflict
        data_addr  <= DATA_BASE + addr_t'((($urandom % 8) << OFFSET_BITS) + (($urandom % 3) << 8));
        data_wdata <= {$urandom, $urandom};
      end
      else
        data_valid <= 1'b0;
    end
  endtask

  task automatic fetch_once(input addr_t addr);
    fetch_valid <= 1'b1;
    fetch_addr  <= addr;
    do
      @(posedge clock);
    while (!fetch_ready);
    fetch_valid <= 1'b0;
    do
      @(posedge clock);
    while (!fetch_resp_valid);
  endtask

  task automatic data_once(input logic write, input addr_t addr, input word_t wdata);
    data_valid <= 1'b1;
    data_write <= write;
    data_addr  <= addr;
    data_wdata <= wdata;
    do
      @(posedge clock);
    while (!data_ready);
    data_valid <= 1'b0;
    if (write)
    begin
      do
        @(posedge clock);
      while (!data_ready);            // Store done when ready returns
    end
    else
    begin
      do
        @(posedge clock);
      while (!data_resp_valid);
    end
  endtask

  // Run limit
  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h1afe6eb6));
    rst         <= 1'b1;
    fetch_valid <= 1'b0;
    fetch_addr  <= '0;
    data_valid  <= 1'b0;
    data_write  <= 1'b0;
    data_addr   <= '0;
    data_wdata  <= '0;
    repeat (5) @(posedge clock);
    rst <= 1'b0;

    fork
      run_fetches(OP_COUNT);
      run_data(OP_COUNT);
    join
    do
      @(posedge clock);
    while (!(fetch_ready && data_ready));

    // Quiet phase, one access at a time
    fetch_once(32'h0000_0200);
    fetch_once(32'h0000_0200);
    data_once(1'b0, 32'h0000_1800, '0);
    data_once(1'b0, 32'h0000_1800, '0);
    data_once(1'b1, 32'h0000_1808, 64'h0123_4567_89ab_cdef);
    data_once(1'b0, 32'h0000_1808, '0);
    data_once(1'b0, 32'h0000_1808, '0);
    data_once(1'b1, 32'h0000_1010, 64'hfeed_0000_beef_1111);
    data_once(1'b0, 32'h0000_1110, '0);   // Same index, replaces the line
    data_once(1'b0, 32'h0000_1010, '0);
    repeat (3) @(posedge clock);

    missing = mem_check.open_fetches + mem_check.open_loads;
    if (missing != 0)
      $display("%0d accepted requests never got a response", missing);
    $display("Closing report: %0d value errors, %0d protocol errors, %0d missing responses",
             mem_check.value_errors, mem_check.protocol_errors, missing);
    if (mem_check.value_errors + mem_check.protocol_errors + missing == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: sources.f
mem_pkg.sv
mem_bus_if.sv
cache_lines.sv
icache_ctrl.sv
dcache_ctrl.sv
bus_arbiter.sv
mem_subsystem.sv
mem_checker.sv
tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mem_subsystem -f sources.f
./obj_dir/Vtb_mem_subsystem > sim.log
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
